//--- Makefile
# Verilator build and run of the serial LSU testbench.

VERILATOR ?= verilator
TOP       ?= serial_lsu_tb
FILELIST  ?= serial_lsu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation stopped without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/lsu_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_port
   import lsu_pkg::*;
(
   input  wire        i_clk,
   input  wire        i_rst_n,
   input  wire        i_go,
   input  word_adr_t  i_adr,
   input  wire        i_store,
   input  word_t      i_dat,
   input  byte_sel_t  i_sel,
   output wb_req_t    o_wb_req,
   input  wire        i_wb_ack,
   output logic       o_ack
);

   word_adr_t adr_q;
   logic      we_q;
   logic      stb_q;

   always_ff @(posedge i_clk) begin
      if (i_go) begin
         adr_q <= i_adr;
         we_q  <= i_store;
      end
   end

   // Strobe holds until the acknowledge.
   always_ff @(posedge i_clk) begin
      if (!i_rst_n)
         stb_q <= 1'b0;
      else if (i_go)
         stb_q <= 1'b1;
      else if (o_ack)
         stb_q <= 1'b0;
   end

   assign o_ack = i_wb_ack & stb_q; // Ack outside the strobe is ignored.

   always_comb begin
      o_wb_req.adr = adr_q;
      o_wb_req.dat = i_dat; // Lanes are idle during the bus phase.
      o_wb_req.sel = i_sel;
      o_wb_req.we  = we_q;
      o_wb_req.stb = stb_q;
   end

endmodule

`default_nettype wire

//--- logic/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Datapath sizes.
`define LSU_XLEN   32
`define LSU_LANES  4
`define LSU_CNT_W  5

// Op encodings, packed as {store, signed_ld, word, half}.
`define LSU_OP_W   4
`define LSU_OP_LB  4'b0100
`define LSU_OP_LBU 4'b0000
`define LSU_OP_LH  4'b0101
`define LSU_OP_LHU 4'b0001
`define LSU_OP_LW  4'b0010
`define LSU_OP_SB  4'b1000
`define LSU_OP_SH  4'b1001
`define LSU_OP_SW  4'b1010

`endif

//--- logic/lsu_lane_shifter.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_lane_shifter
   import lsu_pkg::*;
(
   input  wire        i_clk,
   input  wire        i_en,
   input  wire        i_init,
   input  wire        i_mem_op,
   input  lsu_op_t    i_op,
   input  byte_cnt_t  i_bytecnt,
   input  lsb_t       i_lsb,
   input  wire        i_rs2,
   output logic       o_rd,
   output logic       o_misalign,
   output word_t      o_wb_dat,
   output byte_sel_t  o_wb_sel,
   input  word_t      i_wb_rdt,
   input  wire        i_wb_ack
);

   logic [`LSU_LANES-1:0][7:0] lanes;

   byte_cnt_t dat_sel;
   logic      dat_cur;
   logic      dat_valid;
   logic      signbit;
   logic      misalign;
   logic      wide;
   byte_sel_t fill;
   byte_sel_t drain;
   byte_sel_t lane_en;

   // Upper bytes of a load come from the upper lanes regardless of offset.
   assign dat_sel   = i_bytecnt[1] ? i_bytecnt : (i_bytecnt | i_lsb);
   assign dat_cur   = lanes[dat_sel][0];
   assign dat_valid = i_op.word | (i_bytecnt == 2'd0) | (i_op.half & ~i_bytecnt[1]);

   // Past the access width, send the kept sign bit.
   assign o_rd = i_mem_op & (dat_valid ? dat_cur : (signbit & i_op.signed_ld));

   assign wide = i_op.word | i_op.half;

   // Store fill. Byte 0 goes everywhere, later bytes overwrite by width.
   always_comb begin
      fill[0] = (i_bytecnt == 2'd0);
      fill[1] = fill[0] | ((i_bytecnt == 2'd1) & wide);
      fill[2] = fill[0] | ((i_bytecnt == 2'd2) & i_op.word);
      fill[3] = fill[0] | ((i_bytecnt == 2'd1) & wide) |
                ((i_bytecnt == 2'd3) & i_op.word);
   end

   always_comb begin
      for (int n = 0; n < `LSU_LANES; n++) begin
         drain[n] = (dat_sel == byte_cnt_t'(n));
      end
   end

   assign lane_en = i_en ? (i_init ? fill : drain) : '0;

   always_ff @(posedge i_clk) begin
      for (int n = 0; n < `LSU_LANES; n++) begin
         if (lane_en[n])
            lanes[n] <= {i_rs2, lanes[n][7:1]}; // LSB first.
      end
      if (i_wb_ack)
         lanes <= i_wb_rdt; // Parallel load of read data.
      if (i_en & dat_valid)
         signbit <= dat_cur;
      misalign <= (i_lsb[0] & wide) | (i_lsb[1] & i_op.word);
   end

   assign o_wb_dat = lanes;

   // Byte enables.
   assign o_wb_sel[0] = (i_lsb == 2'd0);
   assign o_wb_sel[1] = (wide & ~i_lsb[1]) | (i_lsb == 2'd1);
   assign o_wb_sel[2] = i_op.word | (i_lsb == 2'd2);
   assign o_wb_sel[3] = i_op.word | (i_op.half & i_lsb[1]) | (i_lsb == 2'd3);

   assign o_misalign = misalign & i_mem_op;

endmodule

`default_nettype wire

//--- logic/lsu_pkg.sv
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

   typedef logic [`LSU_XLEN-1:0]  word_t;
   typedef logic [`LSU_XLEN-3:0]  word_adr_t; // Byte address without the low bits.
   typedef logic [`LSU_LANES-1:0] byte_sel_t;
   typedef logic [1:0]            byte_cnt_t;
   typedef logic [`LSU_CNT_W-1:0] bit_cnt_t;
   typedef logic [1:0]            lsb_t;

   // Neither word nor half set means a byte access.
   typedef struct packed {
      logic store;
      logic signed_ld;
      logic word;
      logic half;
   } lsu_op_t;

   typedef struct packed {
      word_adr_t adr;
      word_t     dat;
      byte_sel_t sel;
      logic      we;
      logic      stb;
   } wb_req_t;

   typedef enum logic [1:0] {
      IDLE,
      SHIFT_IN,
      BUS,
      SHIFT_OUT
   } seq_state_t;

endpackage

`default_nettype wire

//--- logic/lsu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer
   import lsu_pkg::*;
(
   input  wire        i_clk,
   input  wire        i_rst_n,
   input  wire        i_start,
   input  wire        i_store,
   input  wire        i_misalign,
   input  wire        i_ack,
   output logic       o_en,
   output logic       o_init,
   output logic       o_mem_op,
   output logic       o_bus_go,
   output logic       o_rd_valid,
   output logic       o_done,
   output logic       o_misalign,
   output logic       o_busy,
   output byte_cnt_t  o_bytecnt
);

   seq_state_t state;
   bit_cnt_t   cnt;
   logic       go_sent; // Bus request issued for this op.
   logic       done_q;
   logic       last;
   logic       check;

   assign last  = &cnt;
   assign check = (state == BUS) & ~go_sent; // First BUS cycle decides.

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state   <= IDLE;
         cnt     <= '0;
         go_sent <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            IDLE: begin
               if (i_start & ~o_busy) begin
                  state <= SHIFT_IN;
                  cnt   <= '0;
               end
            end
            SHIFT_IN: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  state   <= BUS;
                  go_sent <= 1'b0;
               end
            end
            BUS: begin
               if (check) begin
                  if (i_misalign)
                     state <= IDLE; // Early exit, no bus cycle.
                  else
                     go_sent <= 1'b1;
               end else if (i_ack) begin
                  if (i_store) begin
                     state  <= IDLE;
                     done_q <= 1'b1;
                  end else begin
                     state <= SHIFT_OUT;
                     cnt   <= '0;
                  end
               end
            end
            SHIFT_OUT: begin
               cnt <= cnt + 1'b1;
               if (last) begin
                  state  <= IDLE;
                  done_q <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign o_en       = (state == SHIFT_IN) | (state == SHIFT_OUT);
   assign o_init     = (state == SHIFT_IN);
   assign o_mem_op   = (state != IDLE);
   assign o_bytecnt  = o_en ? cnt[4:3] : 2'd0;
   assign o_bus_go   = check & ~i_misalign;
   assign o_misalign = check & i_misalign;
   assign o_rd_valid = (state == SHIFT_OUT);
   assign o_done     = done_q | o_misalign;
   assign o_busy     = (state != IDLE) | done_q; // Covers the done cycle.

endmodule

`default_nettype wire

//--- logic/serial_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module serial_lsu
   import lsu_pkg::*;
(
   input  wire                 i_clk,
   input  wire                 i_rst_n,
   input  wire                 i_start,
   input  lsu_op_t             i_op,
   input  wire [`LSU_XLEN-1:0] i_adr,
   input  wire                 i_rs2,
   output logic                o_rd,
   output logic                o_rd_valid,
   output logic                o_misalign,
   output logic                o_done,
   output logic                o_busy,
   output wb_req_t             o_wb_req,
   input  word_t               i_wb_rdt,
   input  wire                 i_wb_ack
);

   lsu_op_t              op_q;
   logic [`LSU_XLEN-1:0] adr_q;

   lsb_t      adr_lsb;
   word_adr_t adr_word;
   logic      en;
   logic      init;
   logic      mem_op;
   logic      bus_go;
   logic      bus_ack;
   logic      misalign_lvl;
   byte_cnt_t bytecnt;
   word_t     wb_dat;
   byte_sel_t wb_sel;

   // Request held for the whole operation.
   always_ff @(posedge i_clk) begin
      if (i_start & ~o_busy) begin
         op_q  <= i_op;
         adr_q <= i_adr;
      end
   end

   assign adr_lsb  = adr_q[1:0];
   assign adr_word = adr_q[`LSU_XLEN-1:2];

   lsu_sequencer u_seq (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_start    (i_start),
      .i_store    (op_q.store),
      .i_misalign (misalign_lvl),
      .i_ack      (bus_ack),
      .o_en       (en),
      .o_init     (init),
      .o_mem_op   (mem_op),
      .o_bus_go   (bus_go),
      .o_rd_valid (o_rd_valid),
      .o_done     (o_done),
      .o_misalign (o_misalign),
      .o_busy     (o_busy),
      .o_bytecnt  (bytecnt)
   );

   lsu_lane_shifter u_lanes (
      .i_clk      (i_clk),
      .i_en       (en),
      .i_init     (init),
      .i_mem_op   (mem_op),
      .i_op       (op_q),
      .i_bytecnt  (bytecnt),
      .i_lsb      (adr_lsb),
      .i_rs2      (i_rs2),
      .o_rd       (o_rd),
      .o_misalign (misalign_lvl),
      .o_wb_dat   (wb_dat),
      .o_wb_sel   (wb_sel),
      .i_wb_rdt   (i_wb_rdt),
      .i_wb_ack   (bus_ack)
   );

   lsu_bus_port u_bus (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_go     (bus_go),
      .i_adr    (adr_word),
      .i_store  (op_q.store),
      .i_dat    (wb_dat),
      .i_sel    (wb_sel),
      .o_wb_req (o_wb_req),
      .i_wb_ack (i_wb_ack),
      .o_ack    (bus_ack)
   );

endmodule

`default_nettype wire

//--- serial_lsu.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_sequencer.sv
logic/lsu_lane_shifter.sv
logic/lsu_bus_port.sv
logic/serial_lsu.sv
verification/serial_lsu_props.sv
verification/serial_lsu_tb.sv

//--- verification/serial_lsu_props.sv
`timescale 1ns/1ps
`default_nettype none

module serial_lsu_props (
   input wire i_clk,
   input wire i_rst_n,
   input wire i_go,
   input wire i_hold,
   input wire i_ack,
   input wire i_done
);

   // Request opens only when none is pending.
   go_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_go |-> !i_hold)
      else $error("bus go while a request is open");

   ack_in_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_ack |-> i_hold)
      else $error("acknowledge without an open request");

   drop_on_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_hold && i_ack |=> !i_hold)
      else $error("request held after the acknowledge");

   done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_done |=> !i_done)
      else $error("done longer than one cycle");

endmodule

bind lsu_bus_port serial_lsu_props u_bus_props (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_go    (i_go),
   .i_hold  (stb_q),
   .i_ack   (i_wb_ack), // Raw bus side, not gated by the strobe.
   .i_done  (o_ack)
);

bind lsu_sequencer serial_lsu_props u_seq_props (
   .i_clk   (i_clk),
   .i_rst_n (i_rst_n),
   .i_go    (o_bus_go),
   .i_hold  ((state == BUS) & go_sent),
   .i_ack   (i_ack),
   .i_done  (o_done)
);

`default_nettype wire

//--- verification/serial_lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module serial_lsu_tb
   import lsu_pkg::*;
();

   localparam int CLK_PERIOD = 100;

   typedef struct packed {
      logic [`LSU_OP_W-1:0] op;
      logic [31:0]          adr;
      word_t                sdat; // Serial store data, driven for loads too.
      word_t                mem;  // Word the bus returns.
   } row_t;

   localparam int NROWS = 21;
   localparam row_t ROWS [NROWS] = '{
      '{`LSU_OP_SB,  32'h0000_0100, 32'h1234_56a5, 32'h0000_0000},
      '{`LSU_OP_SB,  32'h0000_0101, 32'hcafe_be3c, 32'h0000_0000},
      '{`LSU_OP_SB,  32'h0000_0102, 32'h7777_7781, 32'h0000_0000},
      '{`LSU_OP_SB,  32'h0000_0103, 32'h0000_00ff, 32'h0000_0000},
      '{`LSU_OP_SH,  32'h0000_0204, 32'hdead_8c71, 32'h0000_0000},
      '{`LSU_OP_SH,  32'h0000_0206, 32'h0bad_f00d, 32'h0000_0000},
      '{`LSU_OP_SW,  32'h0000_0208, 32'h89ab_cdef, 32'h0000_0000},
      '{`LSU_OP_LB,  32'h0000_0300, 32'h5555_aaaa, 32'h80f1_7f23},
      '{`LSU_OP_LB,  32'h0000_0301, 32'h5555_aaaa, 32'h80f1_7f23},
      '{`LSU_OP_LB,  32'h0000_0302, 32'h5555_aaaa, 32'h80f1_7f23},
      '{`LSU_OP_LB,  32'h0000_0303, 32'h5555_aaaa, 32'h80f1_7f23},
      '{`LSU_OP_LBU, 32'h0000_0305, 32'hffff_ffff, 32'he507_9c41},
      '{`LSU_OP_LBU, 32'h0000_0307, 32'hffff_ffff, 32'he507_9c41},
      '{`LSU_OP_LH,  32'h0000_0400, 32'h0f0f_0f0f, 32'h9abc_7123},
      '{`LSU_OP_LH,  32'h0000_0402, 32'h0f0f_0f0f, 32'h9abc_7123},
      '{`LSU_OP_LHU, 32'h0000_0404, 32'h0000_0000, 32'hf00f_8001},
      '{`LSU_OP_LHU, 32'h0000_0406, 32'h0000_0000, 32'hf00f_8001},
      '{`LSU_OP_LW,  32'h0000_0500, 32'h1357_9bdf, 32'ha5c3_0f96},
      '{`LSU_OP_SH,  32'h0000_0601, 32'h1111_2222, 32'h0000_0000},
      '{`LSU_OP_LH,  32'h0000_0603, 32'h0000_0000, 32'h1234_5678},
      '{`LSU_OP_LW,  32'h0000_0602, 32'h0000_0000, 32'h1234_5678}
   };

   localparam int WATCHDOG_CYCLES = NROWS * 120 + 20;

   logic        clk;
   logic        rst_n;
   logic        start;
   lsu_op_t     op;
   logic [31:0] adr;
   logic        rs2;
   logic        rd;
   logic        rd_valid;
   logic        misalign;
   logic        done;
   logic        busy;
   wb_req_t     wb_req;
   word_t       wb_rdt;
   logic        wb_ack;
   integer      seed;
   logic        run_passed;
   logic        fail_reported;

   serial_lsu i_dut (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .i_start    (start),
      .i_op       (op),
      .i_adr      (adr),
      .i_rs2      (rs2),
      .o_rd       (rd),
      .o_rd_valid (rd_valid),
      .o_misalign (misalign),
      .o_done     (done),
      .o_busy     (busy),
      .o_wb_req   (wb_req),
      .i_wb_rdt   (wb_rdt),
      .i_wb_ack   (wb_ack)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic byte_sel_t ref_sel(lsu_op_t o, lsb_t lsb);
      if (o.word)
         return 4'b1111;
      if (o.half)
         return 4'b0011 << lsb;
      return 4'b0001 << lsb;
   endfunction

   // Narrow stores are replicated across the word.
   function automatic word_t ref_store_dat(lsu_op_t o, word_t d);
      if (o.word)
         return d;
      if (o.half)
         return {2{d[15:0]}};
      return {4{d[7:0]}};
   endfunction

   function automatic word_t ref_load(lsu_op_t o, lsb_t lsb, word_t mem);
      logic [15:0] h;
      logic [7:0]  b;
      h = lsb[1] ? mem[31:16] : mem[15:0];
      b = mem[8*lsb +: 8];
      if (o.word)
         return mem;
      if (o.half)
         return {{16{h[15] & o.signed_ld}}, h};
      return {{24{b[7] & o.signed_ld}}, b};
   endfunction

   function automatic logic ref_misalign(lsu_op_t o, lsb_t lsb);
      return (o.half & lsb[0]) | (o.word & (lsb != 2'd0));
   endfunction

   task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
      if (got !== exp) begin
         $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
         fail_reported = 1'b1;
         $display("Something failed");
         $fatal(1, "Stopped at the first mismatch.");
      end
   endtask

   task automatic drive_edge();
      @(posedge clk);
      #1;
   endtask

   task automatic sample_point();
      @(negedge clk);
   endtask

   // One cycle of an open bus request.
   task automatic check_request(input row_t r, input lsu_op_t o);
      expect_equal(32'(wb_req.stb), 32'd1, "stb");
      expect_equal(32'(wb_req.adr), 32'(r.adr[31:2]), "word address");
      expect_equal(32'(wb_req.sel), 32'(ref_sel(o, r.adr[1:0])), "byte select");
      expect_equal(32'(wb_req.we), 32'(o.store), "we");
      if (o.store)
         expect_equal(wb_req.dat, ref_store_dat(o, r.sdat), "store data");
      expect_equal(32'(done), 32'd0, "done in bus phase");
      expect_equal(32'(rd_valid), 32'd0, "rd_valid in bus phase");
      expect_equal(32'(busy), 32'd1, "busy in bus phase");
   endtask

   task automatic run_row(input row_t r);
      lsu_op_t o;
      word_t   got;
      int      waits;
      int      k;
      o = lsu_op_t'(r.op);
      drive_edge();
      start = 1'b1;
      op = o;
      adr = r.adr;
      for (k = 0; k < 32; k++) begin
         drive_edge();
         start = 1'b0;
         rs2 = r.sdat[k]; // LSB first.
         sample_point();
         expect_equal(32'(busy), 32'd1, "busy in shift-in");
         expect_equal(32'(wb_req.stb), 32'd0, "stb in shift-in");
      end
      drive_edge();
      rs2 = 1'b0;
      sample_point();
      expect_equal(32'(misalign), 32'(ref_misalign(o, r.adr[1:0])), "misalign");
      expect_equal(32'(done), 32'(ref_misalign(o, r.adr[1:0])), "done at check");
      expect_equal(32'(wb_req.stb), 32'd0, "stb at check");
      if (!ref_misalign(o, r.adr[1:0])) begin
         waits = $random(seed) & 3;
         drive_edge();
         sample_point();
         check_request(r, o);
         repeat (waits) begin
            drive_edge();
            sample_point();
            check_request(r, o);
         end
         drive_edge();
         wb_ack = 1'b1;
         wb_rdt = r.mem;
         sample_point();
         check_request(r, o);
         drive_edge();
         wb_ack = 1'b0;
         wb_rdt = ~r.mem; // Lanes must ignore data outside the ack.
         sample_point();
         expect_equal(32'(wb_req.stb), 32'd0, "stb after ack");
         if (o.store) begin
            expect_equal(32'(done), 32'd1, "store done");
         end else begin
            got = '0;
            for (k = 0; k < 32; k++) begin
               if (k > 0) begin
                  drive_edge();
                  sample_point();
               end
               expect_equal(32'(rd_valid), 32'd1, "rd_valid in read-out");
               expect_equal(32'(done), 32'd0, "done in read-out");
               got[k] = rd;
            end
            drive_edge();
            sample_point();
            expect_equal(32'(rd_valid), 32'd0, "rd_valid after 32 bits");
            expect_equal(32'(done), 32'd1, "load done");
            expect_equal(got, ref_load(o, r.adr[1:0], r.mem), "load data");
         end
      end
      drive_edge();
      sample_point();
      expect_equal(32'(busy), 32'd0, "busy between operations");
      expect_equal(32'(done), 32'd0, "done between operations");
      expect_equal(32'(wb_req.stb), 32'd0, "stb between operations");
   endtask

   initial begin : main
      int i;
      seed = 32'h01fc_5f55;
      run_passed = 1'b0;
      fail_reported = 1'b0;
      clk = 1'b0;
      rst_n = 1'b0;
      start = 1'b0;
      op = '0;
      adr = '0;
      rs2 = 1'b0;
      wb_rdt = '0;
      wb_ack = 1'b0;
      repeat (10) drive_edge();
      rst_n = 1'b1;
      sample_point();
      expect_equal(32'(wb_req.stb), 32'd0, "stb after reset");
      expect_equal(32'(rd_valid), 32'd0, "rd_valid after reset");
      expect_equal(32'(done), 32'd0, "done after reset");
      expect_equal(32'(misalign), 32'd0, "misalign after reset");
      expect_equal(32'(busy), 32'd0, "busy after reset");
      for (i = 0; i < NROWS; i++)
         run_row(ROWS[i]);
      run_passed = 1'b1;
      $display("Everything OK");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, the operations did not finish in %0d cycles.",
               WATCHDOG_CYCLES);
      fail_reported = 1'b1;
      $display("Something failed");
      $fatal(1, "Run aborted by the watchdog.");
   end

   // Catches a run stopped by an assertion.
   final begin
      if (!run_passed && !fail_reported)
         $display("Something failed");
   end

endmodule

`default_nettype wire
